// File: hdl/noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// port geometry
`define NOC_V        4   // virtual channels per port
`define NOC_P        5   // router ports
`define NOC_B        4   // flit slots per vc
`define NOC_FPAY     32  // payload bits

// flit classes
`define NOC_C        2

// mesh size
`define NOC_NX       4
`define NOC_NY       4

// packets held per vc with non-atomic reallocation
`define NOC_MIN_PCK  2
`define NOC_MAX_PCK  (`NOC_B / `NOC_MIN_PCK)

// one V-bit mask per class, class 0 in the low bits
`define NOC_CLASS_OVC 8'b1100_0011

`endif

// File: hdl/mesh_route_pkg.sv
`include "noc_config.svh"

package mesh_route_pkg;

    localparam int XW = $clog2(`NOC_NX);
    localparam int YW = $clog2(`NOC_NY);

    // router port directions, north lowers y and east raises x
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    // router and endpoint address, one endpoint per router
    typedef struct packed {
        logic [XW-1:0] x;
        logic [YW-1:0] y;
    } r_addr_t;

endpackage

// File: hdl/flit_pkg.sv
`include "noc_config.svh"

package flit_pkg;

    import mesh_route_pkg::*;

    localparam int CLASS_W = (`NOC_C > 1) ? $clog2(`NOC_C) : 1;
    localparam int HDR_RSV_W = `NOC_FPAY - CLASS_W - 2 * $bits(r_addr_t) - $bits(port_e);

    typedef logic [`NOC_V-1:0] vc_mask_t;  // one-hot vc select

    // request over the ports other than our own
    typedef logic [`NOC_P-2:0] port_req_t;

    typedef struct packed {
        logic                 hdr;
        logic                 tail;
        vc_mask_t             vc;
        logic [`NOC_FPAY-1:0] payload;
    } flit_t;

    // payload layout of a header flit
    typedef struct packed {
        logic [HDR_RSV_W-1:0] rsv;
        logic [CLASS_W-1:0]   cls;
        r_addr_t              src;
        r_addr_t              dst;
        port_e                destport;  // port to take at the receiving router
    } hdr_payload_t;

endpackage

// File: hdl/fwft_fifo.sv
module fwft_fifo #(
    parameter int DATA_W = 8,
    parameter int DEPTH  = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] din_i,
    input  logic              wr_en_i,
    input  logic              rd_en_i,
    output logic [DATA_W-1:0] dout_o,
    output logic              not_empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              push;
    logic              pop;

    function automatic logic [AW-1:0] next_ptr(logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // depth need not be a power of 2
    endfunction

    assign push        = wr_en_i && (count != CW'(DEPTH));
    assign pop         = rd_en_i && not_empty_o;
    assign not_empty_o = (count != '0);
    assign dout_o      = mem[rd_ptr];  // oldest entry falls through

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

endmodule

// File: hdl/vc_flit_buffer.sv
`include "noc_config.svh"

module vc_flit_buffer
    import flit_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  flit_t    flit_i,
    input  logic     wr_en_i,
    input  vc_mask_t rd_vc_i,
    output flit_t    flit_o,
    output vc_mask_t vc_not_empty_o
);

    localparam int V  = `NOC_V;
    localparam int B  = `NOC_B;
    localparam int PW = $clog2(B);
    localparam int VW = $clog2(V);
    localparam int CW = $clog2(B + 1);

    // one region of B slots per vc, addressed as {vc, ptr}
    flit_t         mem [V*B];
    logic [PW-1:0] wr_ptr [V];
    logic [PW-1:0] rd_ptr [V];
    logic [CW-1:0] count [V];
    logic [VW-1:0] wr_vc;
    logic [VW-1:0] rd_vc;
    vc_mask_t      push;
    vc_mask_t      pop;

    function automatic logic [VW-1:0] oh_to_idx(vc_mask_t oh);
        logic [VW-1:0] idx;
        idx = '0;
        for (int i = 0; i < V; i++) begin
            if (oh[i]) begin
                idx = idx | VW'(i);
            end
        end
        return idx;
    endfunction

    assign wr_vc = oh_to_idx(flit_i.vc);
    assign rd_vc = oh_to_idx(rd_vc_i);
    assign push  = wr_en_i ? flit_i.vc : '0;
    assign pop   = rd_vc_i & vc_not_empty_o;

    assign flit_o = mem[{rd_vc, rd_ptr[rd_vc]}];  // head of the selected vc

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[{wr_vc, wr_ptr[wr_vc]}] <= flit_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < V; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < V; i++) begin
                if (push[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;  // wraps inside the region
                end
                if (pop[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                case ({push[i], pop[i]})
                    2'b10:   count[i] <= count[i] + 1'b1;
                    2'b01:   count[i] <= count[i] - 1'b1;
                    default: count[i] <= count[i];
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 0; i < V; i++) begin
            vc_not_empty_o[i] = (count[i] != '0);
        end
    end

endmodule

// File: hdl/xy_lookahead_route.sv
module xy_lookahead_route
    import mesh_route_pkg::*;
#(
    parameter port_e SW_LOC = WEST
) (
    input  r_addr_t current_r_addr_i,
    input  r_addr_t dst_i,
    input  port_e   destport_i,
    output port_e   lk_port_o
);

    r_addr_t nb_addr;
    port_e   xy_port;

    // address of the router behind destport_i
    always_comb begin
        nb_addr = current_r_addr_i;
        case (destport_i)
            EAST: begin
                nb_addr.x = current_r_addr_i.x + 1'b1;
            end
            WEST: begin
                nb_addr.x = current_r_addr_i.x - 1'b1;
            end
            NORTH: begin
                nb_addr.y = current_r_addr_i.y - 1'b1;
            end
            SOUTH: begin
                nb_addr.y = current_r_addr_i.y + 1'b1;
            end
            default: begin
                nb_addr = current_r_addr_i;  // ejects here
            end
        endcase
    end

    // xy at the neighbour, x first then y
    always_comb begin
        if (dst_i.x > nb_addr.x) begin
            xy_port = EAST;
        end else if (dst_i.x < nb_addr.x) begin
            xy_port = WEST;
        end else if (dst_i.y > nb_addr.y) begin
            xy_port = SOUTH;
        end else if (dst_i.y < nb_addr.y) begin
            xy_port = NORTH;
        end else begin
            xy_port = LOCAL;
        end
    end

    // no next hop when the flit ejects here or would turn back
    // through the port it came in on
    assign lk_port_o = (destport_i == LOCAL || destport_i == SW_LOC) ? LOCAL : xy_port;

endmodule

// File: hdl/ivc_info_queues.sv
`include "noc_config.svh"

module ivc_info_queues
    import mesh_route_pkg::*;
    import flit_pkg::*;
#(
    parameter port_e SW_LOC = WEST
) (
    input  logic                     clk,
    input  logic                     reset,
    input  flit_t                    flit_i,
    input  logic                     flit_we_i,
    input  r_addr_t                  current_r_addr_i,
    input  vc_mask_t                 rd_vc_i,
    input  vc_mask_t                 reset_ivc_i,
    output vc_mask_t                 flit_is_tail_o,
    output port_req_t [`NOC_V-1:0]   dest_port_o,
    output vc_mask_t [`NOC_V-1:0]    candidate_ovcs_o,
    output port_e [`NOC_V-1:0]       lk_port_o
);

    localparam int V       = `NOC_V;
    localparam int B       = `NOC_B;
    localparam int P       = `NOC_P;
    localparam int MAX_PCK = `NOC_MAX_PCK;
    localparam int PTW     = $bits(port_e);
    localparam logic [`NOC_C*V-1:0] CLASS_OVC = `NOC_CLASS_OVC;

    hdr_payload_t hdr;
    vc_mask_t     flit_wr;
    vc_mask_t     hdr_wr;
    port_e        lk_port_in;

    // one-hot over all ports, then drop our own bit
    function automatic port_req_t port_to_req(port_e p);
        logic [P-1:0] full_oh;
        port_req_t    req;
        full_oh    = '0;
        full_oh[p] = 1'b1;
        req        = '0;
        for (int i = 0; i < P; i++) begin
            if (i < int'(SW_LOC)) begin
                req[i] = full_oh[i];
            end else if (i > int'(SW_LOC)) begin
                req[i-1] = full_oh[i];
            end
        end
        return req;
    endfunction

    assign hdr     = hdr_payload_t'(flit_i.payload);
    assign flit_wr = flit_we_i ? flit_i.vc : '0;
    assign hdr_wr  = (flit_we_i && flit_i.hdr) ? flit_i.vc : '0;

    // queued with the header in the same cycle
    xy_lookahead_route #(
        .SW_LOC(SW_LOC)
    ) lk_route (
        .current_r_addr_i(current_r_addr_i),
        .dst_i           (hdr.dst),
        .destport_i      (hdr.destport),
        .lk_port_o       (lk_port_in)
    );

    for (genvar v = 0; v < V; v++) begin : g_vc
        logic               tail_q;
        logic               tail_ne;
        logic [CLASS_W-1:0] cls_q;
        logic               cls_ne;
        logic [PTW-1:0]     dst_q;
        logic               dst_ne;
        logic [PTW-1:0]     lk_q;
        logic               lk_ne;

        // one entry per flit, popped by the switch grant
        fwft_fifo #(.DATA_W(1), .DEPTH(B)) tail_fifo (
            .clk(clk), .reset(reset),
            .din_i(flit_i.tail), .wr_en_i(flit_wr[v]), .rd_en_i(rd_vc_i[v]),
            .dout_o(tail_q), .not_empty_o(tail_ne)
        );

        // one entry per packet, popped when the vc is released
        fwft_fifo #(.DATA_W(CLASS_W), .DEPTH(MAX_PCK)) class_fifo (
            .clk(clk), .reset(reset),
            .din_i(hdr.cls), .wr_en_i(hdr_wr[v]), .rd_en_i(reset_ivc_i[v]),
            .dout_o(cls_q), .not_empty_o(cls_ne)
        );

        fwft_fifo #(.DATA_W(PTW), .DEPTH(MAX_PCK)) dest_fifo (
            .clk(clk), .reset(reset),
            .din_i(hdr.destport), .wr_en_i(hdr_wr[v]), .rd_en_i(reset_ivc_i[v]),
            .dout_o(dst_q), .not_empty_o(dst_ne)
        );

        fwft_fifo #(.DATA_W(PTW), .DEPTH(MAX_PCK)) lk_fifo (
            .clk(clk), .reset(reset),
            .din_i(lk_port_in), .wr_en_i(hdr_wr[v]), .rd_en_i(reset_ivc_i[v]),
            .dout_o(lk_q), .not_empty_o(lk_ne)
        );

        assign flit_is_tail_o[v]   = tail_q & tail_ne;
        assign candidate_ovcs_o[v] = cls_ne ? CLASS_OVC[cls_q*V +: V] : '0;
        assign dest_port_o[v]      = dst_ne ? port_to_req(port_e'(dst_q)) : '0;
        assign lk_port_o[v]        = lk_ne ? port_e'(lk_q) : LOCAL;
    end

endmodule

// File: hdl/flit_header_update.sv
`include "noc_config.svh"

module flit_header_update
    import mesh_route_pkg::*;
    import flit_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  flit_t                   flit_i,
    input  vc_mask_t                grant_i,
    input  vc_mask_t [`NOC_V-1:0]   assigned_ovc_i,
    input  port_e [`NOC_V-1:0]      lk_port_i,
    output flit_t                   flit_o,
    output logic                    flit_valid_o
);

    localparam int V = `NOC_V;

    vc_mask_t                 ovc_sel;
    logic [$bits(port_e)-1:0] lk_sel;
    hdr_payload_t             hdr_new;
    flit_t                    flit_new;

    // grant is one-hot or zero, so an or-mux is enough
    always_comb begin
        ovc_sel = '0;
        lk_sel  = '0;
        for (int i = 0; i < V; i++) begin
            if (grant_i[i]) begin
                ovc_sel = ovc_sel | assigned_ovc_i[i];
                lk_sel  = lk_sel | lk_port_i[i];
            end
        end
    end

    always_comb begin
        hdr_new          = hdr_payload_t'(flit_i.payload);
        hdr_new.destport = port_e'(lk_sel);  // look-ahead port for the next router
        flit_new         = flit_i;
        flit_new.vc      = ovc_sel;
        if (flit_i.hdr) begin
            flit_new.payload = hdr_new;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant_i) begin
            flit_o <= flit_new;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid_o <= 1'b0;
        end else begin
            flit_valid_o <= |grant_i;  // one cycle per granted flit
        end
    end

endmodule

// File: hdl/input_port.sv
`include "noc_config.svh"

module input_port
    import mesh_route_pkg::*;
    import flit_pkg::*;
#(
    parameter port_e SW_LOC = WEST
) (
    input  logic                    clk,
    input  logic                    reset,
    input  flit_t                   flit_i,
    input  logic                    flit_we_i,
    input  vc_mask_t                sw_grant_i,
    input  vc_mask_t [`NOC_V-1:0]   assigned_ovc_i,
    input  vc_mask_t                reset_ivc_i,
    input  r_addr_t                 current_r_addr_i,
    output vc_mask_t                ivc_request_o,
    output vc_mask_t                flit_is_tail_o,
    output port_req_t [`NOC_V-1:0]  dest_port_o,
    output vc_mask_t [`NOC_V-1:0]   candidate_ovcs_o,
    output flit_t                   flit_out_o,
    output logic                    flit_out_valid_o
);

    flit_t              buf_flit;  // head of the granted vc
    port_e [`NOC_V-1:0] lk_port;

    vc_flit_buffer flit_buf (
        .clk           (clk),
        .reset         (reset),
        .flit_i        (flit_i),
        .wr_en_i       (flit_we_i),
        .rd_vc_i       (sw_grant_i),
        .flit_o        (buf_flit),
        .vc_not_empty_o(ivc_request_o)
    );

    ivc_info_queues #(
        .SW_LOC(SW_LOC)
    ) info_q (
        .clk(clk), .reset(reset),
        .flit_i(flit_i), .flit_we_i(flit_we_i), .current_r_addr_i(current_r_addr_i),
        .rd_vc_i(sw_grant_i), .reset_ivc_i(reset_ivc_i),
        .flit_is_tail_o(flit_is_tail_o), .dest_port_o(dest_port_o),
        .candidate_ovcs_o(candidate_ovcs_o), .lk_port_o(lk_port)
    );

    flit_header_update hdr_upd (
        .clk(clk), .reset(reset),
        .flit_i(buf_flit), .grant_i(sw_grant_i),
        .assigned_ovc_i(assigned_ovc_i), .lk_port_i(lk_port),
        .flit_o(flit_out_o), .flit_valid_o(flit_out_valid_o)
    );

endmodule

// File: sim/tb_input_port.sv
`include "noc_config.svh"

module tb_input_port
    import mesh_route_pkg::*;
    import flit_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int V      = `NOC_V;
    localparam int ROUNDS = 16;
    // directed tests need about 80 cycles, a round at most about 60
    localparam int MAX_CYCLES = 2000;
    localparam r_addr_t CUR_ADDR = '{x: 2'd1, y: 2'd1};

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    flit_t             wr_flit;
    logic              wr_en;
    vc_mask_t          grant;
    vc_mask_t          release_vc;
    vc_mask_t [V-1:0]  assigned_ovc;
    r_addr_t           cur_addr;
    vc_mask_t          ivc_request;
    vc_mask_t          is_tail;
    port_req_t [V-1:0] dest_port;
    vc_mask_t [V-1:0]  cand_ovcs;
    flit_t             out_flit;
    logic              out_valid;

    flit_t             ref_q [V][$];    // flits held per vc
    hdr_payload_t      ref_hdr [V][$];  // headers not yet released
    flit_t             send_q [V][$];   // flits still to be written
    vc_mask_t          exp_req;
    vc_mask_t          exp_tail;
    port_req_t [V-1:0] exp_dest;
    vc_mask_t [V-1:0]  exp_cand;
    flit_t             exp_flit;
    logic              exp_valid;
    int                err_cnt = 0;
    int                err_at_start = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                cycle_cnt = 0;

    input_port #(.SW_LOC(WEST)) dut0 (
        .clk(clk), .reset(reset),
        .flit_i(wr_flit), .flit_we_i(wr_en), .sw_grant_i(grant),
        .assigned_ovc_i(assigned_ovc), .reset_ivc_i(release_vc), .current_r_addr_i(cur_addr),
        .ivc_request_o(ivc_request), .flit_is_tail_o(is_tail), .dest_port_o(dest_port),
        .candidate_ovcs_o(cand_ovcs), .flit_out_o(out_flit), .flit_out_valid_o(out_valid)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // xy at a router, x resolved first
    function automatic port_e xy_port(r_addr_t at, r_addr_t dst);
        if (dst.x > at.x) return EAST;
        if (dst.x < at.x) return WEST;
        if (dst.y > at.y) return SOUTH;
        if (dst.y < at.y) return NORTH;
        return LOCAL;
    endfunction

    function automatic port_e lookahead_port(r_addr_t dst, port_e dp);
        r_addr_t nb;
        nb = CUR_ADDR;
        case (dp)
            EAST:    nb.x = nb.x + 1'b1;
            NORTH:   nb.y = nb.y - 1'b1;
            SOUTH:   nb.y = nb.y + 1'b1;
            default: return LOCAL;  // ejects here, or a u-turn into west
        endcase
        return xy_port(nb, dst);
    endfunction

    function automatic port_req_t port_request(port_e p);
        case (p)  // west is our own port and gets no bit
            LOCAL:   return 4'b0001;
            EAST:    return 4'b0010;
            NORTH:   return 4'b0100;
            SOUTH:   return 4'b1000;
            default: return 4'b0000;
        endcase
    endfunction

    // class 0 takes vcs 0 and 1, class 1 takes vcs 2 and 3
    function automatic vc_mask_t class_mask(logic [CLASS_W-1:0] cls);
        if (cls == '0) return 4'b0011;
        return 4'b1100;
    endfunction

    function automatic flit_t expected_out(flit_t f, vc_mask_t ovc);
        hdr_payload_t h;
        flit_t        o;
        o    = f;
        o.vc = ovc;
        if (f.hdr) begin
            h          = hdr_payload_t'(f.payload);
            h.destport = lookahead_port(h.dst, h.destport);
            o.payload  = h;
        end
        return o;
    endfunction

    function automatic logic work_left();
        for (int v = 0; v < V; v++) begin
            if (send_q[v].size() > 0 || ref_q[v].size() > 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    // reference model, follows the inputs sampled at each rising edge
    always @(posedge clk) begin
        hdr_payload_t h;
        if (reset) begin
            for (int v = 0; v < V; v++) begin
                ref_q[v].delete();
                ref_hdr[v].delete();
            end
            exp_valid = 1'b0;
        end else begin
            exp_valid = 1'b0;
            for (int v = 0; v < V; v++) begin
                if (grant[v] && ref_q[v].size() == 0) begin
                    $display("grant of vc %0d while it holds no flit", v);
                    err_cnt++;
                end else if (grant[v]) begin
                    exp_flit  = expected_out(ref_q[v].pop_front(), assigned_ovc[v]);
                    exp_valid = 1'b1;
                end
                if (release_vc[v] && ref_hdr[v].size() > 0) begin
                    ref_hdr[v].delete(0);
                end
                if (wr_en && wr_flit.vc[v]) begin
                    ref_q[v].push_back(wr_flit);
                    if (wr_flit.hdr) begin
                        ref_hdr[v].push_back(hdr_payload_t'(wr_flit.payload));
                    end
                end
            end
        end
        for (int v = 0; v < V; v++) begin
            exp_req[v]  = (ref_q[v].size() > 0);
            exp_tail[v] = (ref_q[v].size() > 0) ? ref_q[v][0].tail : 1'b0;
            exp_dest[v] = '0;
            exp_cand[v] = '0;
            if (ref_hdr[v].size() > 0) begin
                h           = ref_hdr[v][0];
                exp_dest[v] = port_request(h.destport);
                exp_cand[v] = class_mask(h.cls);
            end
        end
    end

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        err_cnt++;
        $display("Fail %s: got %h, expected %h", name, got, exp);
    endtask

    // outputs and expectations are both settled at the falling edge
    assert property (@(negedge clk) disable iff (reset) ivc_request == exp_req)
        else report_mismatch("ivc_request_o", 64'(ivc_request), 64'(exp_req));
    assert property (@(negedge clk) disable iff (reset) is_tail == exp_tail)
        else report_mismatch("flit_is_tail_o", 64'(is_tail), 64'(exp_tail));
    assert property (@(negedge clk) disable iff (reset) dest_port == exp_dest)
        else report_mismatch("dest_port_o", 64'(dest_port), 64'(exp_dest));
    assert property (@(negedge clk) disable iff (reset) cand_ovcs == exp_cand)
        else report_mismatch("candidate_ovcs_o", 64'(cand_ovcs), 64'(exp_cand));
    assert property (@(negedge clk) disable iff (reset) out_valid == exp_valid)
        else report_mismatch("flit_out_valid_o", 64'(out_valid), 64'(exp_valid));
    assert property (@(negedge clk) disable iff (reset) out_valid |-> out_flit == exp_flit)
        else report_mismatch("flit_out_o", 64'(out_flit), 64'(exp_flit));

    task automatic drive_cycle(logic we, flit_t f, vc_mask_t gnt, vc_mask_t rel);
        wr_en      = we;
        wr_flit    = f;
        grant      = gnt;
        release_vc = rel;
        @(posedge clk);
        #1;
        wr_en      = 1'b0;
        grant      = '0;
        release_vc = '0;
    endtask

    task automatic build_packet(int v, int len);
        hdr_payload_t h;
        flit_t        f;
        do begin
            h.dst.x = 2'($urandom_range(0, `NOC_NX - 1));
            h.dst.y = 2'($urandom_range(0, `NOC_NY - 1));
        end while (xy_port(CUR_ADDR, h.dst) == WEST);  // west is where it came from
        h.rsv      = HDR_RSV_W'($urandom());
        h.cls      = CLASS_W'($urandom_range(0, `NOC_C - 1));
        h.src      = CUR_ADDR;
        h.destport = xy_port(CUR_ADDR, h.dst);
        for (int i = 0; i < len; i++) begin
            f.hdr  = (i == 0);
            f.tail = (i == len - 1);
            f.vc   = vc_mask_t'(1 << v);
            if (i == 0) begin
                f.payload = h;
            end else begin
                f.payload = $urandom();
            end
            send_q[v].push_back(f);
        end
    endtask

    task automatic write_queued(int v);
        while (send_q[v].size() > 0) begin
            drive_cycle(1'b1, send_q[v].pop_front(), '0, '0);
        end
    endtask

    // grants up to the tail, then releases the vc
    task automatic grant_packet(int v);
        logic last;
        last = 1'b0;
        while (!last) begin
            last = ref_q[v][0].tail;
            drive_cycle(1'b0, '0, vc_mask_t'(1 << v), '0);
        end
        drive_cycle(1'b0, '0, '0, vc_mask_t'(1 << v));
    endtask

    task automatic interleave_round();
        flit_t    f;
        logic     we;
        vc_mask_t gnt;
        vc_mask_t rel;
        vc_mask_t next_rel;
        int       rr;
        int       w;
        int       g;
        rel = '0;
        rr  = 0;
        for (int v = 0; v < V; v++) begin
            build_packet(v, $urandom_range(2, 4));
        end
        while (work_left() || rel != '0) begin
            we       = 1'b0;
            f        = '0;
            gnt      = '0;
            next_rel = '0;
            for (int k = 0; k < V; k++) begin
                w = (rr + k) % V;
                if (!we && send_q[w].size() > 0) begin
                    we = 1'b1;
                    f  = send_q[w].pop_front();
                    rr = w + 1;
                end
            end
            w = $urandom_range(0, V - 1);
            if ($urandom_range(0, 3) != 0) begin  // switch idles now and then
                for (int k = 0; k < V; k++) begin
                    g = (w + k) % V;
                    if (gnt == '0 && ref_q[g].size() > 0) begin
                        gnt = vc_mask_t'(1 << g);
                        next_rel = ref_q[g][0].tail ? gnt : '0;
                    end
                end
            end
            drive_cycle(we, f, gnt, rel);
            rel = next_rel;
        end
    endtask

    task automatic start_test();
        int rot;
        err_at_start = err_cnt;
        rot = $urandom_range(1, V - 1);
        for (int v = 0; v < V; v++) begin
            assigned_ovc[v] = vc_mask_t'(1 << ((v + rot) % V));  // distinct, never its own vc
        end
    endtask

    task automatic finish_test(string name);
        if (err_cnt == err_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_cnt - err_at_start);
        end
    endtask

    initial begin
        int           v;
        hdr_payload_t first_hdr;
        hdr_payload_t second_hdr;
        void'($urandom(37));
        wr_en      = 1'b0;
        wr_flit    = '0;
        grant      = '0;
        release_vc = '0;
        cur_addr   = CUR_ADDR;
        assigned_ovc = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test();
        repeat (3) drive_cycle(1'b0, '0, '0, '0);
        v = $urandom_range(0, V - 1);
        build_packet(v, 2);
        write_queued(v);
        grant_packet(v);
        finish_test("single packet");

        start_test();
        for (int i = 0; i < V; i++) begin
            build_packet(i, $urandom_range(2, 4));
            write_queued(i);
        end
        for (int i = 0; i < V; i++) begin
            grant_packet(i);
        end
        finish_test("header decode on all vcs");

        start_test();
        for (int r = 0; r < ROUNDS; r++) begin
            interleave_round();
        end
        finish_test("interleaved packets");

        start_test();
        v = $urandom_range(0, V - 1);
        do begin  // second header differs so the release shows on the outputs
            send_q[v].delete();
            build_packet(v, 2);
            build_packet(v, 2);
            first_hdr  = hdr_payload_t'(send_q[v][0].payload);
            second_hdr = hdr_payload_t'(send_q[v][2].payload);
        end while (first_hdr.destport == second_hdr.destport
                   && first_hdr.cls == second_hdr.cls);
        write_queued(v);
        grant_packet(v);
        grant_packet(v);
        finish_test("two packets in one vc");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/mesh_route_pkg.sv
hdl/flit_pkg.sv
hdl/fwft_fifo.sv
hdl/vc_flit_buffer.sv
hdl/xy_lookahead_route.sv
hdl/ivc_info_queues.sv
hdl/flit_header_update.sv
hdl/input_port.sv
sim/tb_input_port.sv

// File: Makefile
TOP := tb_input_port

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
